// File: all.f
+incdir+hw
+incdir+tb
hw/lsu_op_pkg.sv
hw/lsu_pipe_pkg.sv
hw/lsu_ctrl.sv
hw/lsu_dcache.sv
hw/lsu_victim_queue.sv
hw/lsu_ex.sv
hw/lsu_top.sv
tb/lsu_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= lsu_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation completed successfully

SOURCES := $(wildcard hw/*.sv hw/*.svh tb/*.sv tb/*.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "FAIL: pass line not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/lsu_tb_table.svh
/* Directed LSU request sequence, one row per cycle with the outputs
   expected two cycles later */

`ifndef LSU_TB_TABLE_SVH
`define LSU_TB_TABLE_SVH

// A and B share index 0 with different tags, C and D use indices 1 and 2
localparam logic [31:0] ADDR_A    = 32'h0000_0040;
localparam logic [31:0] ADDR_B    = 32'h0000_0080;
localparam logic [31:0] ADDR_C    = 32'h0000_0104;
localparam logic [31:0] ADDR_D    = 32'h0000_0208;
localparam logic [31:0] ADDR_MISS = 32'h0000_0300;

task automatic build_table();
    int fill_a;
    int fill_a2;
    int fill_b;
    int fill_c;
    int fill_d;
    int st_c;
    int st_tmp;

    begin_test("miss then fill hit");
    load(lsu_op_pkg::OP_LW, ADDR_MISS, 5'd1, 1'b0, -1);
    fill(ADDR_A, 32'h0, 5'd2, 1'b0, 1'b1, fill_a);
    load(lsu_op_pkg::OP_LW, ADDR_A, 5'd3, 1'b1, fill_a);

    // Bits 7 and 15 forced high so both loads extend with ones
    begin_test("byte and half sign extension");
    fill(ADDR_C, 32'h0000_8080, 5'd4, 1'b0, 1'b1, fill_c);
    load(lsu_op_pkg::OP_LB, ADDR_C, 5'd5, 1'b1, fill_c);
    load(lsu_op_pkg::OP_LH, ADDR_C, 5'd6, 1'b1, fill_c);

    begin_test("eviction and victim queue hit");
    fill(ADDR_B, 32'h0, 5'd7, 1'b0, 1'b1, fill_b);
    load(lsu_op_pkg::OP_LW, ADDR_A, 5'd8, 1'b1, fill_a);
    load(lsu_op_pkg::OP_LW, ADDR_B, 5'd9, 1'b1, fill_b);
    // Refill of A hits its victim entry and must drop it
    fill(ADDR_A, 32'h0, 5'd10, 1'b0, 1'b0, fill_a2);
    load(lsu_op_pkg::OP_LW, ADDR_A, 5'd11, 1'b1, fill_a2);
    load(lsu_op_pkg::OP_LW, ADDR_B, 5'd12, 1'b1, fill_b);

    begin_test("stores");
    store(ADDR_C, 32'h1234_5678, 5'd13, 1'b0, 1'b1, fill_c, st_tmp);
    store(ADDR_C, 32'hcafe_f00d, 5'd14, 1'b1, 1'b1, -1, st_c);
    load(lsu_op_pkg::OP_LW, ADDR_C, 5'd15, 1'b1, st_c);
    store(ADDR_D, 32'h0bad_beef, 5'd16, 1'b1, 1'b0, -1, st_tmp);

    begin_test("fill replay");
    fill(ADDR_D, 32'h0, 5'd17, 1'b1, 1'b1, fill_d);
    load(lsu_op_pkg::OP_LW, ADDR_D, 5'd18, 1'b1, fill_d);

    // The killed retiring store leaves line C as it was
    begin_test("flush and back to back");
    store(ADDR_C, 32'hdead_0001, 5'd19, 1'b1, 1'b1, -1, st_tmp);
    load(lsu_op_pkg::OP_LW, ADDR_C, 5'd20, 1'b1, st_c);
    flush_last();
    load(lsu_op_pkg::OP_LW, ADDR_C, 5'd21, 1'b1, st_c);
    load(lsu_op_pkg::OP_LH, ADDR_A, 5'd22, 1'b1, fill_a2);
    load(lsu_op_pkg::OP_LB, ADDR_B, 5'd23, 1'b1, fill_b);
endtask

`endif

// File: tb/lsu_tb.sv
/* LSU back end testbench: applies a request table one row per cycle
   and checks the CDB and LQ/SQ outputs two cycles later */

`timescale 1ns/100ps

`include "lsu_defs.svh"

module lsu_tb;

    localparam int LQ_W        = `LSU_LQ_DEPTH;
    localparam int SQ_W        = `LSU_SQ_DEPTH;
    localparam int DRAIN_LIMIT = 10;

    // Request, flush and expected outputs of one cycle
    typedef struct packed {
        lsu_pipe_pkg::lsu_req_t      req;
        logic                        valid;
        logic                        flush;
        logic                        exp_cdb;
        logic                        exp_lq;
        logic                        exp_sq;
        logic                        chk_lsq;
        logic                        exp_retry;
        logic                        exp_replay;
        logic [`LSU_DATA_WIDTH-1:0]  exp_data;
        logic [3:0]                  test_id;
    } row_t;

    logic                       clk;
    logic                       rst_n;
    logic                       flush;
    logic                       req_valid;
    lsu_pipe_pkg::lsu_req_t     req;
    logic                       cdb_valid;
    lsu_pipe_pkg::cdb_t         cdb;
    logic                       lq_en;
    logic                       sq_en;
    lsu_pipe_pkg::lsq_update_t  lsq_upd;

    row_t    rows[$];
    string   test_names[$];
    int      test_errors[16];
    int      cur_test;
    int      checks;
    int      errors;
    integer  seed;

    lsu_top i_dut (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_flush        (flush),
        .i_req_valid    (req_valid),
        .i_req          (req),
        .o_cdb_valid    (cdb_valid),
        .o_cdb          (cdb),
        .o_lq_update_en (lq_en),
        .o_sq_update_en (sq_en),
        .o_lsq_update   (lsq_upd)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] sign_extend_load(lsu_op_pkg::op_e op, logic [31:0] w);
        case (op)
            lsu_op_pkg::OP_LB: return {{24{w[7]}}, w[7:0]};
            lsu_op_pkg::OP_LH: return {{16{w[15]}}, w[15:0]};
            default:           return w;
        endcase
    endfunction

    function automatic lsu_pipe_pkg::lsu_req_t make_req(lsu_op_pkg::op_e op,
            logic [31:0] addr, logic [31:0] data, logic [4:0] tag, logic retire,
            logic replay);
        lsu_pipe_pkg::lsu_req_t r;
        r.op          = op;
        r.addr        = addr;
        r.data        = data;
        r.tag         = tag;
        // Select vectors derived from the tag so each row has its own
        r.lq_select   = LQ_W'(1) << tag[2:0];
        r.sq_select   = SQ_W'(1) << (tag[2:0] + 3'd1);
        r.retire      = retire;
        r.fill_replay = replay;
        return r;
    endfunction

    task automatic begin_test(input string name);
        test_names.push_back(name);
        cur_test = test_names.size() - 1;
    endtask

    task automatic push_row(input lsu_pipe_pkg::lsu_req_t req_in, input logic exp_cdb,
            input logic exp_lq, input logic exp_sq, input logic exp_retry,
            input logic exp_replay, input logic [31:0] exp_data);
        row_t r;
        r            = '0;
        r.req        = req_in;
        r.valid      = 1'b1;
        r.exp_cdb    = exp_cdb;
        r.exp_lq     = exp_lq;
        r.exp_sq     = exp_sq;
        r.chk_lsq    = 1'b1;
        r.exp_retry  = exp_retry;
        r.exp_replay = exp_replay;
        r.exp_data   = exp_data;
        r.test_id    = 4'(cur_test);
        rows.push_back(r);
    endtask

    // Fill data is random, with some bits forced high by the mask
    task automatic fill(input logic [31:0] addr, input logic [31:0] or_mask,
            input logic [4:0] tag, input logic replay, input logic exp_retry,
            output int idx);
        logic [31:0] d;
        d = $random(seed) | or_mask;
        idx = rows.size();
        push_row(make_req(lsu_op_pkg::OP_FILL, addr, d, tag, 1'b0, replay),
                 1'b0, 1'b0, 1'b0, exp_retry, replay, 32'h0);
    endtask

    task automatic load(input lsu_op_pkg::op_e op, input logic [31:0] addr,
            input logic [4:0] tag, input logic hit, input int src);
        logic [31:0] d;
        d = '0;
        if (hit) begin
            d = sign_extend_load(op, rows[src].req.data);
        end
        push_row(make_req(op, addr, 32'h0, tag, 1'b0, 1'b0), hit, 1'b1, 1'b0, !hit, 1'b0, d);
    endtask

    // A non-retiring store broadcasts the word currently held for its line
    task automatic store(input logic [31:0] addr, input logic [31:0] data,
            input logic [4:0] tag, input logic retire, input logic hit, input int src,
            output int idx);
        logic [31:0] d;
        d = '0;
        if (!retire) begin
            d = rows[src].req.data;
        end
        idx = rows.size();
        push_row(make_req(lsu_op_pkg::OP_ST, addr, data, tag, retire, 1'b0),
                 !retire, 1'b0, retire, !hit, 1'b0, d);
    endtask

    // Flush kills the request being offered and the one in the memory stage
    task automatic flush_last();
        int last;
        last = rows.size() - 1;
        rows[last].flush = 1'b1;
        for (int k = last - 1; k <= last; k++) begin
            rows[k].exp_cdb = 1'b0;
            rows[k].exp_lq  = 1'b0;
            rows[k].exp_sq  = 1'b0;
            rows[k].chk_lsq = 1'b0;
        end
    endtask

    `include "lsu_tb_table.svh"

    task automatic check_value(input int k, input string what, input logic [31:0] got,
            input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            test_errors[rows[k].test_id]++;
            $display("mismatch at %0t: row %0d %s got %h expected %h",
                     $time, k, what, got, exp);
        end
    endtask

    task automatic check_row(input int k);
        row_t r;
        r = rows[k];
        check_value(k, "cdb_valid", cdb_valid, r.exp_cdb);
        check_value(k, "lq_update_en", lq_en, r.exp_lq);
        check_value(k, "sq_update_en", sq_en, r.exp_sq);
        if (r.exp_cdb) begin
            check_value(k, "cdb data", cdb.data, r.exp_data);
            check_value(k, "cdb tag", cdb.tag, r.req.tag);
        end
        if (r.chk_lsq) begin
            check_value(k, "lq_select", lsq_upd.lq_select, r.req.lq_select);
            check_value(k, "sq_select", lsq_upd.sq_select, r.req.sq_select);
            check_value(k, "retry", lsq_upd.retry, r.exp_retry);
            check_value(k, "replay", lsq_upd.replay, r.exp_replay);
        end
        // Last row of a test closes it
        if (k == rows.size() - 1 || rows[k + 1].test_id != r.test_id) begin
            $display("test %0d (%s): %s, %0d errors", r.test_id, test_names[r.test_id],
                     test_errors[r.test_id] == 0 ? "passed" : "failed",
                     test_errors[r.test_id]);
        end
    endtask

    task automatic drive_row(input int k);
        req_valid = rows[k].valid;
        req       = rows[k].req;
        flush     = rows[k].flush;
    endtask

    initial begin
        int next_check;
        int waited;
        logic timed_out;
        clk        = 1'b0;
        rst_n      = 1'b0;
        flush      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        seed       = 17;
        checks     = 0;
        errors     = 0;
        next_check = 0;
        timed_out  = 1'b0;
        build_table();

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int k = 0; k < rows.size(); k++) begin
            @(posedge clk);
            #1;
            if (k >= 2) begin
                check_row(next_check);
                next_check++;
            end
            drive_row(k);
        end

        // Drain the last two rows with the request side idle
        waited = 0;
        while (next_check < rows.size() && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            req_valid = 1'b0;
            flush     = 1'b0;
            check_row(next_check);
            next_check++;
            waited++;
        end
        if (next_check < rows.size()) begin
            $display("timeout: results of the last rows did not come out in time");
            timed_out = 1'b1;
        end

        $display("checks: %0d total, %0d passed, %0d failed",
                 checks, checks - errors, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: hw/lsu_top.sv
/* LSU back end top level: control, data cache, victim queue
   and execute stage */

`timescale 1ns/100ps

`include "lsu_defs.svh"

module lsu_top (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_flush,

    input  logic                        i_req_valid,
    input  lsu_pipe_pkg::lsu_req_t      i_req,

    output logic                        o_cdb_valid,
    output lsu_pipe_pkg::cdb_t          o_cdb,
    output logic                        o_lq_update_en,
    output logic                        o_sq_update_en,
    output lsu_pipe_pkg::lsq_update_t   o_lsq_update
);

    logic                        mem_valid;
    lsu_pipe_pkg::mem_stage_t    mem;

    logic                        dc_hit;
    logic [`LSU_DATA_WIDTH-1:0]  dc_data;
    logic                        vq_hit;
    logic [`LSU_DATA_WIDTH-1:0]  vq_data;

    logic                        evict_valid;
    logic [`LSU_ADDR_WIDTH-1:0]  evict_addr;
    logic [`LSU_DATA_WIDTH-1:0]  evict_data;

    lsu_ctrl u_ctrl (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_flush     (i_flush),
        .i_req_valid (i_req_valid),
        .i_req       (i_req),
        .o_mem_valid (mem_valid),
        .o_mem       (mem)
    );

    lsu_dcache u_dcache (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_mem_valid   (mem_valid),
        .i_mem         (mem),
        .i_flush       (i_flush),
        .o_hit         (dc_hit),
        .o_data        (dc_data),
        .o_evict_valid (evict_valid),
        .o_evict_addr  (evict_addr),
        .o_evict_data  (evict_data)
    );

    lsu_victim_queue u_victim_queue (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_mem_valid   (mem_valid),
        .i_mem         (mem),
        .i_flush       (i_flush),
        .i_evict_valid (evict_valid),
        .i_evict_addr  (evict_addr),
        .i_evict_data  (evict_data),
        .o_hit         (vq_hit),
        .o_data        (vq_data)
    );

    lsu_ex u_ex (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_flush        (i_flush),
        .i_mem_valid    (mem_valid),
        .i_mem          (mem),
        .i_dc_hit       (dc_hit),
        .i_dc_data      (dc_data),
        .i_vq_hit       (vq_hit),
        .i_vq_data      (vq_data),
        .o_cdb_valid    (o_cdb_valid),
        .o_cdb          (o_cdb),
        .o_lq_update_en (o_lq_update_en),
        .o_sq_update_en (o_sq_update_en),
        .o_lsq_update   (o_lsq_update)
    );

endmodule

// File: hw/lsu_ex.sv
/* LSU execute stage: merges cache and victim data, sign-extends loads,
   and registers the CDB broadcast and the LQ/SQ update */

`timescale 1ns/100ps

`include "lsu_defs.svh"

module lsu_ex (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_flush,

    // Memory stage
    input  logic                          i_mem_valid,
    input  lsu_pipe_pkg::mem_stage_t      i_mem,

    // Lookup results
    input  logic                          i_dc_hit,
    input  logic [`LSU_DATA_WIDTH-1:0]    i_dc_data,
    input  logic                          i_vq_hit,
    input  logic [`LSU_DATA_WIDTH-1:0]    i_vq_data,

    // CDB broadcast
    output logic                          o_cdb_valid,
    output lsu_pipe_pkg::cdb_t            o_cdb,

    // LQ/SQ feedback
    output logic                          o_lq_update_en,
    output logic                          o_sq_update_en,
    output lsu_pipe_pkg::lsq_update_t     o_lsq_update
);

    localparam int DATA_W = `LSU_DATA_WIDTH;

    logic               live;
    logic               any_hit;
    logic               cdb_valid;
    logic               lq_en;
    logic               sq_en;
    logic [DATA_W-1:0]  raw_data;
    logic [DATA_W-1:0]  load_data;

    assign live    = i_mem_valid & ~i_flush;
    assign any_hit = i_dc_hit | i_vq_hit;

    // Stores always complete, loads only when some source hit
    assign cdb_valid = live & ~i_mem.op_is.fill & ~i_mem.req.retire
                     & (i_mem.op_is.store | any_hit);
    assign lq_en = live & i_mem.op_is.load;
    assign sq_en = live & i_mem.req.retire;

    // Victim queue data wins over the cache
    assign raw_data = i_vq_hit ? i_vq_data : i_dc_data;

    always_comb begin
        case (i_mem.req.op)
            lsu_op_pkg::OP_LB: load_data = {{(DATA_W-8){raw_data[7]}}, raw_data[7:0]};
            lsu_op_pkg::OP_LH: load_data = {{(DATA_W-16){raw_data[15]}}, raw_data[15:0]};
            default:           load_data = raw_data;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_cdb_valid    <= 1'b0;
            o_lq_update_en <= 1'b0;
            o_sq_update_en <= 1'b0;
        end else begin
            o_cdb_valid    <= cdb_valid;
            o_lq_update_en <= lq_en;
            o_sq_update_en <= sq_en;
        end
    end

    always_ff @(posedge i_clk) begin
        o_cdb.data             <= load_data;
        o_cdb.tag              <= i_mem.req.tag;
        o_lsq_update.lq_select <= i_mem.req.lq_select;
        o_lsq_update.sq_select <= i_mem.req.sq_select;
        // Miss in both places, the queue has to try again
        o_lsq_update.retry     <= ~any_hit;
        o_lsq_update.replay    <= i_mem.req.fill_replay;
    end

endmodule

// File: hw/lsu_victim_queue.sv
/* Victim queue: circular buffer of evicted lines with fully
   associative lookup and invalidation when a fill returns a line */

`timescale 1ns/100ps

`include "lsu_defs.svh"

module lsu_victim_queue (
    input  logic                        i_clk,
    input  logic                        i_rst_n,

    input  logic                        i_mem_valid,
    input  lsu_pipe_pkg::mem_stage_t    i_mem,
    input  logic                        i_flush,

    // Line displaced by the cache
    input  logic                        i_evict_valid,
    input  logic [`LSU_ADDR_WIDTH-1:0]  i_evict_addr,
    input  logic [`LSU_DATA_WIDTH-1:0]  i_evict_data,

    output logic                        o_hit,
    output logic [`LSU_DATA_WIDTH-1:0]  o_data
);

    localparam int DATA_W = `LSU_DATA_WIDTH;
    localparam int ADDR_W = `LSU_ADDR_WIDTH;
    localparam int DEPTH  = `LSU_VQ_DEPTH;
    localparam int OFF_W  = $clog2(DATA_W / 8);
    localparam int LINE_W = ADDR_W - OFF_W;
    localparam int PTR_W  = $clog2(DEPTH);

    logic [DEPTH-1:0]   valid_q;
    logic [LINE_W-1:0]  line_q [DEPTH];
    logic [DATA_W-1:0]  data_q [DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;

    logic [DEPTH-1:0]   match;
    logic               fill_inv;

    // Search every entry by line address
    always_comb begin
        match  = '0;
        o_data = '0;
        for (int i = 0; i < DEPTH; i++) begin
            match[i] = valid_q[i] & (line_q[i] == i_mem.req.addr[ADDR_W-1:OFF_W]);
            if (match[i]) begin
                o_data = o_data | data_q[i];
            end
        end
    end

    assign o_hit    = i_mem_valid & (|match);
    assign fill_inv = i_mem_valid & ~i_flush & i_mem.op_is.fill;

    // Push at the write pointer, which overwrites the oldest entry once full
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            valid_q  <= '0;
            wr_ptr_q <= '0;
        end else begin
            if (fill_inv) begin
                valid_q <= valid_q & ~match;
            end
            if (i_evict_valid) begin
                valid_q[wr_ptr_q] <= 1'b1;
                wr_ptr_q          <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_evict_valid) begin
            line_q[wr_ptr_q] <= i_evict_addr[ADDR_W-1:OFF_W];
            data_q[wr_ptr_q] <= i_evict_data;
        end
    end

    // A line lives in at most one entry
    a_single_match: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        $onehot0(match)
    );

endmodule

// File: hw/lsu_dcache.sv
/* Direct-mapped data cache, one word per line; combinational lookup,
   fill and retiring-store writes, and eviction of displaced lines */

`timescale 1ns/100ps

`include "lsu_defs.svh"

module lsu_dcache (
    input  logic                        i_clk,
    input  logic                        i_rst_n,

    input  logic                        i_mem_valid,
    input  lsu_pipe_pkg::mem_stage_t    i_mem,
    input  logic                        i_flush,

    // Lookup result to the execute stage
    output logic                        o_hit,
    output logic [`LSU_DATA_WIDTH-1:0]  o_data,

    // Displaced line to the victim queue
    output logic                        o_evict_valid,
    output logic [`LSU_ADDR_WIDTH-1:0]  o_evict_addr,
    output logic [`LSU_DATA_WIDTH-1:0]  o_evict_data
);

    localparam int DATA_W = `LSU_DATA_WIDTH;
    localparam int ADDR_W = `LSU_ADDR_WIDTH;
    localparam int SETS   = `LSU_DC_SETS;
    localparam int OFF_W  = $clog2(DATA_W / 8);
    localparam int IDX_W  = $clog2(SETS);
    localparam int TAG_W  = ADDR_W - IDX_W - OFF_W;

    logic [SETS-1:0]    valid_q;
    logic [TAG_W-1:0]   tag_q  [SETS];
    logic [DATA_W-1:0]  data_q [SETS];

    logic [IDX_W-1:0]   idx;
    logic [TAG_W-1:0]   tag;
    logic               tag_match;
    logic               active;
    logic               fill_we;
    logic               store_we;

    // Index above the byte offset, tag above the index
    assign idx = i_mem.req.addr[OFF_W +: IDX_W];
    assign tag = i_mem.req.addr[ADDR_W-1 -: TAG_W];

    assign tag_match = valid_q[idx] & (tag_q[idx] == tag);
    assign o_hit     = i_mem_valid & tag_match;
    assign o_data    = data_q[idx];

    assign active   = i_mem_valid & ~i_flush;
    assign fill_we  = active & i_mem.op_is.fill;
    // Retiring stores only write a line that is already present
    assign store_we = active & i_mem.op_is.store & i_mem.req.retire & tag_match;

    // A fill pushes out a valid line holding another address
    assign o_evict_valid = fill_we & valid_q[idx] & (tag_q[idx] != tag);
    assign o_evict_addr  = {tag_q[idx], idx, {OFF_W{1'b0}}};
    assign o_evict_data  = data_q[idx];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            valid_q <= '0;
        end else if (fill_we) begin
            valid_q[idx] <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (fill_we) begin
            tag_q[idx]  <= tag;
            data_q[idx] <= i_mem.req.data;
        end else if (store_we) begin
            data_q[idx] <= i_mem.req.data;
        end
    end

    // Evictions come only from an operation whose opcode is a fill
    a_evict_on_fill: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_evict_valid |-> i_mem.req.op == lsu_op_pkg::OP_FILL
    );

endmodule

// File: hw/lsu_ctrl.sv
/* LSU control: decodes incoming requests, applies flush and holds
   the memory stage valid and payload registers */

`timescale 1ns/100ps

module lsu_ctrl (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_flush,

    // Request side
    input  logic                      i_req_valid,
    input  lsu_pipe_pkg::lsu_req_t    i_req,

    // Memory stage
    output logic                      o_mem_valid,
    output lsu_pipe_pkg::mem_stage_t  o_mem
);

    lsu_op_pkg::op_is_t  req_op_is;
    logic                req_take;

    // Decode the opcode into its class bits
    always_comb begin
        req_op_is = lsu_op_pkg::OP_IS_NONE;
        case (i_req.op)
            lsu_op_pkg::OP_FILL: req_op_is.fill  = 1'b1;
            lsu_op_pkg::OP_LB,
            lsu_op_pkg::OP_LH,
            lsu_op_pkg::OP_LW:   req_op_is.load  = 1'b1;
            lsu_op_pkg::OP_ST:   req_op_is.store = 1'b1;
            default:             req_op_is       = lsu_op_pkg::OP_IS_NONE;
        endcase
    end

    // Flush blocks entry of the request being offered
    assign req_take = i_req_valid & ~i_flush;

    // Stage valid, cleared by reset and by flush
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_mem_valid <= 1'b0;
        end else begin
            o_mem_valid <= req_take;
        end
    end

    // Payload follows the request every cycle
    always_ff @(posedge i_clk) begin
        o_mem.req   <= i_req;
        o_mem.op_is <= req_op_is;
    end

    // Only stores may retire through the LSU
    a_retire_is_store: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_req_valid && i_req.retire |-> i_req.op == lsu_op_pkg::OP_ST
    );

endmodule

// File: hw/lsu_pipe_pkg.sv
/* LSU pipeline payloads: request, memory stage, CDB broadcast
   and LQ/SQ update */

`include "lsu_defs.svh"

package lsu_pipe_pkg;

    // Request as offered by the issue side
    typedef struct packed {
        lsu_op_pkg::op_e                op;
        logic [`LSU_ADDR_WIDTH-1:0]     addr;
        logic [`LSU_DATA_WIDTH-1:0]     data;
        logic [`LSU_ROB_IDX_WIDTH-1:0]  tag;
        logic [`LSU_LQ_DEPTH-1:0]       lq_select;
        logic [`LSU_SQ_DEPTH-1:0]       sq_select;
        logic                           retire;
        logic                           fill_replay;
    } lsu_req_t;

    // Request plus its decoded class, held in the memory stage
    typedef struct packed {
        lsu_req_t                       req;
        lsu_op_pkg::op_is_t             op_is;
    } mem_stage_t;

    // Common data bus result
    typedef struct packed {
        logic [`LSU_DATA_WIDTH-1:0]     data;
        logic [`LSU_ROB_IDX_WIDTH-1:0]  tag;
    } cdb_t;

    // Feedback to the load and store queues
    typedef struct packed {
        logic [`LSU_LQ_DEPTH-1:0]       lq_select;
        logic [`LSU_SQ_DEPTH-1:0]       sq_select;
        logic                           retry;
        logic                           replay;
    } lsq_update_t;

endpackage

// File: hw/lsu_op_pkg.sv
/* LSU operation types: the opcode enum and its decoded class bits */

package lsu_op_pkg;

    // Memory operations accepted by the request stage
    // Loads are all sign-extending
    typedef enum logic [2:0] {
        OP_FILL = 3'd0,
        OP_LB   = 3'd1,
        OP_LH   = 3'd2,
        OP_LW   = 3'd3,
        OP_ST   = 3'd4
    } op_e;

    // Decoded operation class, one bit per kind
    typedef struct packed {
        logic load;
        logic store;
        logic fill;
    } op_is_t;

    // Idle value for a decoded class
    localparam op_is_t OP_IS_NONE = '{
        load:  1'b0,
        store: 1'b0,
        fill:  1'b0
    };

endpackage

// File: hw/lsu_defs.svh
/* LSU subsystem sizing macros: word, address, tag and select widths,
   plus data cache and victim queue sizes */

`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Datapath widths
`define LSU_DATA_WIDTH      32
`define LSU_ADDR_WIDTH      32

// ROB tag carried with every operation
`define LSU_ROB_IDX_WIDTH   5

// One-hot select vectors into the load and store queues
`define LSU_LQ_DEPTH        8
`define LSU_SQ_DEPTH        8

// Direct-mapped cache, one word per line
`define LSU_DC_SETS         16

// Victim queue entries
`define LSU_VQ_DEPTH        4

`endif
